/* verilog/serial_link_defines.svh */
////////////////////
// Size parameters of the serial link
// Included by the packages and by every block that sizes its own registers
////////////////////

`ifndef SERIAL_LINK_DEFINES_SVH
`define SERIAL_LINK_DEFINES_SVH

// Physical link
`define SL_NUM_LANES     4
`define SL_FLIT_BITS     (2 * `SL_NUM_LANES)
`define SL_SLICE_BITS    (`SL_FLIT_BITS - 2)

// Message framing and flow control
`define SL_PAYLOAD_BITS  24
`define SL_NUM_SPLITS    (`SL_PAYLOAD_BITS / `SL_SLICE_BITS)
`define SL_NUM_CREDITS   4
`define SL_FIFO_DEPTH    (`SL_NUM_CREDITS * `SL_NUM_SPLITS)

`endif

/* verilog/serial_link_pkg.sv */
////////////////////
// Message-level types shared by the SoC-facing side of the link
////////////////////

`default_nettype none

`include "serial_link_defines.svh"

package serial_link_pkg;

  // Kind of message carried over the link
  typedef enum logic [1:0] {
    tag_read  = 2'd0,
    tag_write = 2'd1,
    tag_resp  = 2'd2,
    tag_user  = 2'd3
  } tag_e;

  // One SoC message, data sits in the low bits and leaves the link first
  typedef struct packed {
    tag_e        tag;
    logic [5:0]  addr;
    logic [15:0] data;
  } sl_msg_t;

  // Wide enough to hold the full credit count, zero included
  typedef logic [$clog2(`SL_NUM_CREDITS + 1)-1:0] credit_t;

endpackage

`default_nettype wire

/* verilog/phy_pkg.sv */
////////////////////
// Flit-level types for the words that travel on the link
// Every word carries its kind in the top bit
////////////////////

`default_nettype none

`include "serial_link_defines.svh"

package phy_pkg;

  typedef enum logic {
    kind_data   = 1'b0,
    kind_credit = 1'b1
  } flit_kind_e;

  // Slice of a message
  typedef struct packed {
    flit_kind_e                kind;
    logic                      last;
    logic [`SL_SLICE_BITS-1:0] slice;
  } data_flit_t;

  // Returned receive slots, counted in whole messages
  typedef struct packed {
    flit_kind_e                kind;
    serial_link_pkg::credit_t  count;
    logic [`SL_FLIT_BITS-2-$bits(serial_link_pkg::credit_t):0] pad;
  } credit_flit_t;

  // One link word seen either way
  typedef union packed {
    data_flit_t   data;
    credit_flit_t credit;
  } phy_word_t;

endpackage

`default_nettype wire

/* verilog/sl_packetizer.sv */
////////////////////
// Transmit side of the link. Splits messages into data flits, spends
// credits per message and returns freed receive slots as credit flits
////////////////////

`default_nettype none

`include "serial_link_defines.svh"

module sl_packetizer (
  input  wire logic                     clk_i,
  input  wire logic                     rst_i,
  // SoC message input
  input  wire serial_link_pkg::sl_msg_t msg_i,
  input  wire logic                     msg_valid_i,
  output logic                          msg_ready_o,
  // Credits coming back from the far end
  input  wire logic                     credit_valid_i,
  input  wire serial_link_pkg::credit_t credit_cnt_i,
  // Local receive slots freed by the consumer
  input  wire logic                     slot_freed_i,
  // Link output
  output phy_pkg::phy_word_t            phy_o,
  output logic                          phy_valid_o
);

  import serial_link_pkg::*;
  import phy_pkg::*;

  localparam int cnt_bits = $clog2(`SL_NUM_SPLITS);
  localparam logic [cnt_bits-1:0] last_idx = cnt_bits'(`SL_NUM_SPLITS - 1);

  logic [`SL_PAYLOAD_BITS-1:0] shreg;
  logic [cnt_bits-1:0]         split_cnt;
  logic                        busy;
  credit_t                     tx_credits;
  credit_t                     pending;

  logic         accept;
  logic         send_credit;
  logic         send_data;
  logic         last_split;
  data_flit_t   data_flit;
  credit_flit_t credit_flit;

  // Take a new message only when idle and the far end has room
  assign msg_ready_o = ~busy & (tx_credits != '0);
  assign accept      = msg_valid_i & msg_ready_o;

  // Credit return wins the link, data waits one cycle
  assign send_credit = (pending != '0);
  assign send_data   = busy & ~send_credit;
  assign last_split  = (split_cnt == last_idx);

  always_comb begin
    data_flit.kind    = kind_data;
    data_flit.last    = last_split;
    data_flit.slice   = shreg[`SL_SLICE_BITS-1:0];
    credit_flit.kind  = kind_credit;
    credit_flit.count = pending;
    credit_flit.pad   = '0;
  end

  ////////////////////
  // Splitting
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy        <= 1'b0;
      split_cnt   <= '0;
      phy_valid_o <= 1'b0;
    end else begin
      phy_valid_o <= send_credit | busy;
      if (accept) begin
        busy <= 1'b1;
      end else if (send_data) begin
        split_cnt <= split_cnt + 1'b1;
        if (last_split) begin
          busy <= 1'b0;
        end
      end
    end
  end

  // Message shift register, lowest slice goes out first
  always_ff @(posedge clk_i) begin
    if (accept) begin
      shreg <= msg_i;
    end else if (send_data) begin
      shreg <= shreg >> `SL_SLICE_BITS;
    end
    if (send_credit) begin
      phy_o.credit <= credit_flit;
    end else begin
      phy_o.data <= data_flit;
    end
  end

  ////////////////////
  // Credit accounting
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      tx_credits <= credit_t'(`SL_NUM_CREDITS);
      pending    <= '0;
    end else begin
      tx_credits <= tx_credits + (credit_valid_i ? credit_cnt_i : credit_t'(0))
                    - credit_t'(accept);
      // Whole pending count leaves in one flit, a new pulse starts the next
      if (send_credit) begin
        pending <= credit_t'(slot_freed_i);
      end else if (slot_freed_i) begin
        pending <= pending + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/sl_rx_fifo.sv */
////////////////////
// Receive buffer of the link. Stores data flits for the consumer and
// turns credit flits into a one-cycle credit pulse
////////////////////

`default_nettype none

`include "serial_link_defines.svh"

module sl_rx_fifo (
  input  wire logic                     clk_i,
  input  wire logic                     rst_i,
  // Link input
  input  wire phy_pkg::phy_word_t       phy_i,
  input  wire logic                     phy_valid_i,
  // Credits returned by the far end
  output logic                          credit_valid_o,
  output serial_link_pkg::credit_t      credit_cnt_o,
  // Flits towards the consumer
  output phy_pkg::data_flit_t           flit_o,
  output logic                          flit_valid_o,
  input  wire logic                     flit_pop_i
);

  import phy_pkg::*;

  localparam int ptr_bits = $clog2(`SL_FIFO_DEPTH);
  localparam int cnt_bits = $clog2(`SL_FIFO_DEPTH + 1);

  data_flit_t          mem [`SL_FIFO_DEPTH];
  logic [ptr_bits-1:0] wr_ptr;
  logic [ptr_bits-1:0] rd_ptr;
  logic [cnt_bits-1:0] count;

  logic push;
  logic pop;
  logic is_credit;

  // Kind bit sits in the same place in both views
  assign push      = phy_valid_i & (phy_i.data.kind == kind_data);
  assign is_credit = phy_valid_i & (phy_i.credit.kind == kind_credit);
  assign pop       = flit_pop_i & flit_valid_o;

  assign flit_valid_o = (count != '0);
  assign flit_o       = mem[rd_ptr];

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr] <= phy_i.data;
    end
  end

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  ////////////////////
  // Credit pulse
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      credit_valid_o <= 1'b0;
    end else begin
      credit_valid_o <= is_credit;
    end
  end

  always_ff @(posedge clk_i) begin
    credit_cnt_o <= phy_i.credit.count;
  end

endmodule

`default_nettype wire

/* verilog/sl_depacketizer.sv */
////////////////////
// Consumer side of the link. Rebuilds messages from flits and holds
// each one until the SoC takes it
////////////////////

`default_nettype none

`include "serial_link_defines.svh"

module sl_depacketizer (
  input  wire logic                     clk_i,
  input  wire logic                     rst_i,
  // Flits from the receive buffer
  input  wire phy_pkg::data_flit_t      flit_i,
  input  wire logic                     flit_valid_i,
  output logic                          flit_pop_o,
  // SoC message output
  output serial_link_pkg::sl_msg_t      msg_o,
  output logic                          msg_valid_o,
  input  wire logic                     msg_ready_i,
  // One pulse per message handed out
  output logic                          slot_freed_o
);

  import serial_link_pkg::*;

  logic [`SL_PAYLOAD_BITS-1:0] asm_q;
  logic [`SL_PAYLOAD_BITS-1:0] asm_next;
  logic                        msg_done;

  // Stall the buffer while a finished message waits
  assign flit_pop_o   = flit_valid_i & ~msg_valid_o;
  assign msg_done     = flit_pop_o & flit_i.last;
  assign slot_freed_o = msg_valid_o & msg_ready_i;

  // New slice enters at the top, first slice ends up lowest
  assign asm_next = {flit_i.slice, asm_q[`SL_PAYLOAD_BITS-1:`SL_SLICE_BITS]};

  ////////////////////
  // Assembly
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (flit_pop_o) begin
      asm_q <= asm_next;
    end
    if (msg_done) begin
      msg_o <= sl_msg_t'(asm_next);
    end
  end

  // Output holding register
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      msg_valid_o <= 1'b0;
    end else if (msg_done) begin
      msg_valid_o <= 1'b1;
    end else if (slot_freed_o) begin
      msg_valid_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* verilog/serial_link.sv */
////////////////////
// Serial link top. Packetizer drives the link, receive buffer and
// depacketizer take the incoming link back to messages
////////////////////

`default_nettype none

module serial_link (
  input  wire logic                     clk_i,
  input  wire logic                     rst_i,
  // SoC message input
  input  wire serial_link_pkg::sl_msg_t msg_i,
  input  wire logic                     msg_valid_i,
  output logic                          msg_ready_o,
  // SoC message output
  output serial_link_pkg::sl_msg_t      msg_o,
  output logic                          msg_valid_o,
  input  wire logic                     msg_ready_i,
  // Link
  output phy_pkg::phy_word_t            phy_o,
  output logic                          phy_valid_o,
  input  wire phy_pkg::phy_word_t       phy_i,
  input  wire logic                     phy_valid_i
);

  import serial_link_pkg::*;
  import phy_pkg::*;

  logic       credit_valid;
  credit_t    credit_cnt;
  logic       slot_freed;
  data_flit_t flit;
  logic       flit_valid;
  logic       flit_pop;

  sl_packetizer i_packetizer (
    .clk_i          ( clk_i        ),
    .rst_i          ( rst_i        ),
    .msg_i          ( msg_i        ),
    .msg_valid_i    ( msg_valid_i  ),
    .msg_ready_o    ( msg_ready_o  ),
    .credit_valid_i ( credit_valid ),
    .credit_cnt_i   ( credit_cnt   ),
    .slot_freed_i   ( slot_freed   ),
    .phy_o          ( phy_o        ),
    .phy_valid_o    ( phy_valid_o  )
  );

  sl_rx_fifo i_rx_fifo (
    .clk_i          ( clk_i        ),
    .rst_i          ( rst_i        ),
    .phy_i          ( phy_i        ),
    .phy_valid_i    ( phy_valid_i  ),
    .credit_valid_o ( credit_valid ),
    .credit_cnt_o   ( credit_cnt   ),
    .flit_o         ( flit         ),
    .flit_valid_o   ( flit_valid   ),
    .flit_pop_i     ( flit_pop     )
  );

  sl_depacketizer i_depacketizer (
    .clk_i          ( clk_i        ),
    .rst_i          ( rst_i        ),
    .flit_i         ( flit         ),
    .flit_valid_i   ( flit_valid   ),
    .flit_pop_o     ( flit_pop     ),
    .msg_o          ( msg_o        ),
    .msg_valid_o    ( msg_valid_o  ),
    .msg_ready_i    ( msg_ready_i  ),
    .slot_freed_o   ( slot_freed   )
  );

endmodule

`default_nettype wire

/* verification/tb_serial_link_model.svh */
////////////////////
// Reference model of the serial link, included inside its testbench
// Queues accepted messages and rebuilds them from the flits on the link
////////////////////

serial_link_pkg::sl_msg_t    exp_q[$];
serial_link_pkg::sl_msg_t    tx_q[$];
int                          acc_cnt    = 0;
int                          delivered  = 0;
int                          credit_sum = 0;
int                          split_idx  = 0;
logic [`SL_PAYLOAD_BITS-1:0] asm_bits   = '0;

task automatic stop_run(input string why);
  $display("%s", why);
  $display("Finished with errors");
  $fatal(1);
endtask

task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
  if (actual !== expected)
    stop_run($sformatf("ERR @%0t: %s, got 0x%0h expected 0x%0h",
                       $time, what, actual, expected));
endtask

// Messages leave the link in the order they were accepted
task automatic check_delivery(input serial_link_pkg::sl_msg_t m);
  if (exp_q.size() == 0) begin
    stop_run("A message came out of the link while none was outstanding");
  end else begin
    check_value(32'(m), 32'(exp_q.pop_front()), "delivered message");
    delivered++;
  end
endtask

task automatic observe_link_word(input phy_pkg::phy_word_t w);
  if (w.data.kind == phy_pkg::kind_credit) begin
    credit_sum += int'(w.credit.count);
  end else begin
    // Slices arrive lowest first
    asm_bits = asm_bits | (`SL_PAYLOAD_BITS'(w.data.slice) << (split_idx * `SL_SLICE_BITS));
    check_value(32'(w.data.last), 32'(split_idx == `SL_NUM_SPLITS - 1), "last flag");
    split_idx++;
    if (split_idx == `SL_NUM_SPLITS) begin
      if (tx_q.size() == 0)
        stop_run("Data flits appeared on the link without an accepted message");
      else
        check_value(32'(asm_bits), 32'(tx_q.pop_front()), "slices on the link");
      split_idx = 0;
      asm_bits  = '0;
    end
  end
endtask

/* verification/tb_serial_link.sv */
////////////////////
// Testbench for the serial link with its link output looped back to its
// input. Random traffic and back-pressure are checked against a queue model
////////////////////

`default_nettype none

`include "serial_link_defines.svh"

module tb_serial_link;

  import serial_link_pkg::*;
  import phy_pkg::*;

  localparam int n_random     = 300;
  localparam int n_resume     = 20;
  localparam int n_planned    = n_random + `SL_NUM_CREDITS + n_resume + 2;
  localparam int idle_cycles  = 8;
  localparam int stall_cycles = 15 * `SL_NUM_CREDITS;

  logic      clk_i;
  logic      rst_i;
  sl_msg_t   msg_i;
  logic      msg_valid_i;
  logic      msg_ready_o;
  sl_msg_t   msg_o;
  logic      msg_valid_o;
  logic      msg_ready_i;
  phy_word_t phy_o;
  logic      phy_valid_o;

  `include "tb_serial_link_model.svh"

  // Loopback of the link
  serial_link serial_link_i (.*, .phy_i (phy_o), .phy_valid_i (phy_valid_o));

  initial begin
    clk_i = 1'b0;
    forever begin
      #2 clk_i = ~clk_i;
    end
  end

  // Monitor, sampled halfway between rising edges
  always @(negedge clk_i) begin
    if (!rst_i) begin
      if (msg_valid_i && msg_ready_o) begin
        exp_q.push_back(msg_i);
        tx_q.push_back(msg_i);
        acc_cnt++;
      end
      if (msg_valid_o && msg_ready_i)
        check_delivery(msg_o);
      if (phy_valid_o)
        observe_link_word(phy_o);
    end
  end

  // One clock of stimulus, a held message stays stable until taken
  task automatic drive_step(input bit want, input bit ready);
    @(posedge clk_i);
    if (!msg_valid_i || msg_ready_o) begin
      msg_valid_i <= want;
      msg_i       <= sl_msg_t'(`SL_PAYLOAD_BITS'($urandom));
    end
    msg_ready_i <= ready;
  endtask

  task automatic drain_link();
    while (msg_valid_i || exp_q.size() != 0)
      drive_step(1'b0, $urandom_range(0, 1) != 0);
    // Room for the last credit flit to travel back
    repeat (idle_cycles)
      drive_step(1'b0, 1'b0);
  endtask

  initial begin
    repeat (200 * n_planned) @(posedge clk_i);
    stop_run("Timeout: the link stopped delivering messages");
  end

  initial begin
    int target;
    int stall_start;
    void'($urandom(32'h5de9_1855));
    rst_i       = 1'b1;
    msg_i       = '0;
    msg_valid_i = 1'b0;
    msg_ready_i = 1'b0;
    repeat (2) @(posedge clk_i);
    rst_i <= 1'b0;

    @(negedge clk_i);
    check_value(32'(msg_ready_o), 32'd1, "msg_ready_o after reset");
    check_value(32'(msg_valid_o), 32'd0, "msg_valid_o after reset");
    check_value(32'(phy_valid_o), 32'd0, "phy_valid_o after reset");

    // Random traffic under random back-pressure
    while (acc_cnt < n_random)
      drive_step($urandom_range(0, 2) != 0, $urandom_range(0, 3) != 0);
    drain_link();

    ////////////////////
    // Consumer stalled until credits run out
    ////////////////////
    stall_start = acc_cnt;
    repeat (stall_cycles)
      drive_step(1'b1, 1'b0);
    @(negedge clk_i);
    check_value(32'(acc_cnt - stall_start), `SL_NUM_CREDITS, "messages taken while stalled");
    check_value(32'(msg_ready_o), 32'd0, "msg_ready_o with no credits left");

    // Released again, held messages drain and acceptance resumes
    target = acc_cnt + n_resume;
    while (acc_cnt < target)
      drive_step($urandom_range(0, 2) != 0, $urandom_range(0, 3) != 0);
    drain_link();

    check_value(32'(split_idx), 32'd0, "flits of an unfinished message");
    check_value(32'(tx_q.size()), 32'd0, "messages never seen on the link");
    check_value(32'(credit_sum), 32'(delivered), "credits returned on the link");
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+verilog
+incdir+verification
verilog/serial_link_pkg.sv
verilog/phy_pkg.sv
verilog/sl_packetizer.sv
verilog/sl_rx_fifo.sv
verilog/sl_depacketizer.sv
verilog/serial_link.sv
verification/tb_serial_link.sv
